// File: testbench/rename_golden.txt
# one row per clock cycle, hex fields, ff marks an output that is not checked
# dv sa sb ds cv ct fl | rdy sat sbt nt ot rv rd rt
# rename after reset, sources chained, dest also a source
01 01 02 03 00 00 00 01 01 02 20 03 00 ff ff
01 03 04 05 00 00 00 01 20 04 21 05 00 ff ff
01 05 03 03 00 00 00 01 21 20 22 20 00 ff ff
01 00 07 07 00 00 00 01 00 07 23 07 00 ff ff
# completions out of order, retire in dispatch order
00 00 00 00 01 21 00 01 ff ff ff ff 00 ff ff
00 00 00 00 01 23 00 01 ff ff ff ff 00 ff ff
00 00 00 00 01 20 00 01 ff ff ff ff 00 ff ff
00 00 00 00 00 00 00 01 ff ff ff ff 00 ff ff
00 00 00 00 00 00 00 01 ff ff ff ff 01 03 20
00 00 00 00 01 22 00 01 ff ff ff ff 01 05 21
00 00 00 00 00 00 00 01 ff ff ff ff 00 ff ff
00 00 00 00 00 00 00 01 ff ff ff ff 01 03 22
# eight outstanding, freed tags 03 05 20 07 come back in order
01 03 05 08 00 00 00 01 22 21 24 08 01 07 23
01 08 07 09 00 00 00 01 24 23 25 09 00 ff ff
01 09 00 0a 00 00 00 01 25 00 26 0a 00 ff ff
01 0a 00 0b 00 00 00 01 26 00 27 0b 00 ff ff
01 0b 00 0c 00 00 00 01 27 00 03 0c 00 ff ff
01 0c 00 0d 00 00 00 01 03 00 05 0d 00 ff ff
01 0d 00 0e 00 00 00 01 05 00 20 0e 00 ff ff
01 0e 00 0f 00 00 00 01 20 00 07 0f 00 ff ff
# back-pressure held until the head retires
01 0f 00 10 01 24 00 00 07 00 ff 10 00 ff ff
01 0f 00 10 00 00 00 00 07 00 ff 10 00 ff ff
01 0f 00 10 00 00 00 01 07 00 08 10 01 08 24
00 00 00 00 01 25 00 00 ff ff ff ff 00 ff ff
00 00 00 00 00 00 00 00 ff ff ff ff 00 ff ff
00 00 00 00 01 26 00 01 ff ff ff ff 01 09 25
# flush, done but unretired entry discarded
00 00 00 00 00 00 01 00 ff ff ff ff 00 ff ff
01 09 0a 03 00 00 00 01 25 0a 26 22 00 ff ff
01 03 10 10 00 00 00 01 26 10 27 10 00 ff ff
00 00 00 00 01 26 00 01 ff ff ff ff 00 ff ff
00 00 00 00 01 27 00 01 ff ff ff ff 00 ff ff
00 00 00 00 00 00 00 01 ff ff ff ff 01 03 26
01 03 10 14 00 00 00 01 26 27 03 14 01 10 27
00 00 00 00 00 00 00 01 ff ff ff ff 00 ff ff

// File: rename_core.f
hw/rename_pkg.sv
hw/rename_if.sv
hw/rename_stage.sv
hw/reorder_buffer.sv
hw/retire_stage.sv
hw/rename_core.sv
testbench/tb_clock_gen.sv
testbench/rename_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rename_core_tb
FILELIST  = rename_core.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/rename_core_tb.sv
`default_nettype none

module rename_core_tb;

  localparam string golden_path  = "testbench/rename_golden.txt";
  localparam int    clock_period = 10;
  localparam int    reset_cycles = 4;
  // inputs settle just after the edge, outputs sampled just before the next
  localparam int    drive_delay  = 1;
  localparam int    check_delay  = 7;
  localparam int    slack_time   = 200;
  // golden field value for an output that is not checked
  localparam logic [7:0] dont_care = 8'hff;

  // one golden row, fields in file column order
  typedef struct packed {
    logic [7:0] dispatch_valid;
    logic [7:0] src_a;
    logic [7:0] src_b;
    logic [7:0] dest;
    logic [7:0] complete_valid;
    logic [7:0] complete_tag;
    logic [7:0] flush;
    logic [7:0] dispatch_ready;
    logic [7:0] src_a_tag;
    logic [7:0] src_b_tag;
    logic [7:0] new_tag;
    logic [7:0] old_tag;
    logic [7:0] retire_valid;
    logic [7:0] retire_dest;
    logic [7:0] retire_tag;
  } golden_row_t;

  golden_row_t rows [$];
  int          row_num     = 0;
  logic        rows_loaded = 1'b0;

  logic                  clock;
  logic                  reset;
  logic                  dispatch_valid;
  rename_pkg::arch_reg_t src_a;
  rename_pkg::arch_reg_t src_b;
  rename_pkg::arch_reg_t dest;
  logic                  complete_valid;
  rename_pkg::phys_reg_t complete_tag;
  logic                  flush;
  logic                  dispatch_ready;
  rename_pkg::phys_reg_t src_a_tag;
  rename_pkg::phys_reg_t src_b_tag;
  rename_pkg::phys_reg_t new_tag;
  rename_pkg::phys_reg_t old_tag;
  logic                  retire_valid;
  rename_pkg::arch_reg_t retire_dest;
  rename_pkg::phys_reg_t retire_tag;

  tb_clock_gen #(.half_period(clock_period / 2), .reset_cycles(reset_cycles)) clock_gen (
    .clock, .reset
  );

  rename_core uut (
    .clock, .reset, .dispatch_valid, .src_a, .src_b, .dest, .complete_valid,
    .complete_tag, .flush, .dispatch_ready, .src_a_tag, .src_b_tag, .new_tag,
    .old_tag, .retire_valid, .retire_dest, .retire_tag
  );

  //////////////////////////////////////////////////////////////////////
  // failure and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_tag(input string what, input rename_pkg::phys_reg_t actual,
                           input rename_pkg::phys_reg_t expected);
    if (actual !== expected) begin
      $display("Fail at time %0t: row %0d %s is %0d, expected %0d",
               $time, row_num, what, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic check_reg(input string what, input rename_pkg::arch_reg_t actual,
                           input rename_pkg::arch_reg_t expected);
    if (actual !== expected) begin
      $display("Fail at time %0t: row %0d %s is r%0d, expected r%0d",
               $time, row_num, what, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Fail at time %0t: row %0d %s is %b, expected %b",
               $time, row_num, what, actual, expected);
      stop_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // golden file
  //////////////////////////////////////////////////////////////////////

  task automatic load_golden();
    int          fd;
    int          fields;
    string       line;
    golden_row_t row;
    logic [7:0]  dv, sa, sb, ds, cv, ct, fl;
    logic [7:0]  rdy, sat, sbt, nt, ot, rv, rd, rt;
    fd = $fopen(golden_path, "r");
    if (fd == 0) begin
      $display("could not open the golden vector file %s", golden_path);
      stop_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      // blank lines and '#' notes carry no vector
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       dv, sa, sb, ds, cv, ct, fl, rdy, sat, sbt, nt, ot, rv, rd, rt);
      if (fields != 15) begin
        $display("golden vector line has %0d fields instead of 15: %s", fields, line);
        stop_with_failure();
      end
      row = '{dv, sa, sb, ds, cv, ct, fl, rdy, sat, sbt, nt, ot, rv, rd, rt};
      rows.push_back(row);
    end
    $fclose(fd);
    if (rows.size() == 0) begin
      $display("golden vector file %s holds no vectors", golden_path);
      stop_with_failure();
    end
  endtask

  task automatic apply_inputs(input golden_row_t row);
    dispatch_valid = row.dispatch_valid[0];
    src_a          = row.src_a[4:0];
    src_b          = row.src_b[4:0];
    dest           = row.dest[4:0];
    complete_valid = row.complete_valid[0];
    complete_tag   = row.complete_tag[5:0];
    flush          = row.flush[0];
  endtask

  // retire fields reflect the pop at the previous edge
  task automatic check_outputs(input golden_row_t row);
    if (row.dispatch_ready != dont_care)
      check_bit("dispatch_ready", dispatch_ready, row.dispatch_ready[0]);
    if (row.src_a_tag != dont_care) check_tag("src_a_tag", src_a_tag, row.src_a_tag[5:0]);
    if (row.src_b_tag != dont_care) check_tag("src_b_tag", src_b_tag, row.src_b_tag[5:0]);
    if (row.new_tag != dont_care) check_tag("new_tag", new_tag, row.new_tag[5:0]);
    if (row.old_tag != dont_care) check_tag("old_tag", old_tag, row.old_tag[5:0]);
    if (row.retire_valid != dont_care)
      check_bit("retire_valid", retire_valid, row.retire_valid[0]);
    if (row.retire_dest != dont_care)
      check_reg("retire_dest", retire_dest, row.retire_dest[4:0]);
    if (row.retire_tag != dont_care) check_tag("retire_tag", retire_tag, row.retire_tag[5:0]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    dispatch_valid = 1'b0;
    src_a          = '0;
    src_b          = '0;
    dest           = '0;
    complete_valid = 1'b0;
    complete_tag   = '0;
    flush          = 1'b0;
    load_golden();
    rows_loaded = 1'b1;
    // first edge always sees reset high
    @(posedge clock);
    while (reset) @(posedge clock);
    foreach (rows[i]) begin
      row_num = i + 1;
      #(drive_delay);
      apply_inputs(rows[i]);
      #(check_delay);
      check_outputs(rows[i]);
      @(posedge clock);
    end
    $display("All tests passed");
    $finish;
  end

  // one clock per row plus reset and some slack
  initial begin
    wait (rows_loaded);
    #((rows.size() + reset_cycles) * clock_period + slack_time);
    $display("watchdog expired before all golden vectors were applied");
    stop_with_failure();
  end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 4
) (
  output logic clock,
  output logic reset
);

  // free running, first rising edge at one half period
  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // reset held over a fixed count of rising edges
  // released with the edge so the last reset edge still sees it high
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: hw/rename_core.sv
`default_nettype none

module rename_core (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  rename_pkg::arch_reg_t src_a,
  input  rename_pkg::arch_reg_t src_b,
  input  rename_pkg::arch_reg_t dest,
  input  logic                  complete_valid,
  input  rename_pkg::phys_reg_t complete_tag,
  input  logic                  flush,
  output logic                  dispatch_ready,
  output rename_pkg::phys_reg_t src_a_tag,
  output rename_pkg::phys_reg_t src_b_tag,
  output rename_pkg::phys_reg_t new_tag,
  output rename_pkg::phys_reg_t old_tag,
  output logic                  retire_valid,
  output rename_pkg::arch_reg_t retire_dest,
  output rename_pkg::phys_reg_t retire_tag
);

  dispatch_if disp_bus ();
  retire_if   ret_bus ();

  // retire back to rename
  rename_pkg::arch_map_t arch_map;
  logic                  freed_valid;
  rename_pkg::phys_reg_t freed_tag;

  // allocated and replaced tags seen at the dispatch port
  assign new_tag = disp_bus.new_tag;
  assign old_tag = disp_bus.old_tag;

  rename_stage #(.num_phys_regs(rename_pkg::NUM_PHYS_REGS)) u_rename (
    .clock, .reset, .flush, .dispatch_valid, .src_a, .src_b, .dest,
    .src_a_tag, .src_b_tag, .dispatch_ready, .arch_map, .freed_valid,
    .freed_tag, .disp(disp_bus)
  );

  reorder_buffer #(.rob_depth(rename_pkg::ROB_DEPTH)) u_rob (
    .clock, .reset, .flush, .complete_valid, .complete_tag,
    .disp(disp_bus), .ret(ret_bus)
  );

  retire_stage u_retire (
    .clock, .reset, .ret(ret_bus), .arch_map, .freed_valid, .freed_tag,
    .retire_valid, .retire_dest, .retire_tag
  );

endmodule

`default_nettype wire

// File: hw/retire_stage.sv
`default_nettype none

module retire_stage (
  input  logic                  clock,
  input  logic                  reset,
  retire_if.consumer            ret,
  output rename_pkg::arch_map_t arch_map,
  output logic                  freed_valid,
  output rename_pkg::phys_reg_t freed_tag,
  output logic                  retire_valid,
  output rename_pkg::arch_reg_t retire_dest,
  output rename_pkg::phys_reg_t retire_tag
);

  // replaced tag goes straight back to the free list
  assign freed_valid = ret.valid;
  assign freed_tag   = ret.old_tag;

  // committed mapping, identity out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
        arch_map[r] <= rename_pkg::phys_reg_t'(r);
      end
    end else if (ret.valid) begin
      arch_map[ret.arch_dest] <= ret.new_tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // retirement report, one cycle per pop
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= ret.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ret.valid) begin
      retire_dest <= ret.arch_dest;
      retire_tag  <= ret.new_tag;
    end
  end

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
`default_nettype none

module reorder_buffer #(
  parameter int rob_depth = rename_pkg::ROB_DEPTH
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  complete_valid,
  input  rename_pkg::phys_reg_t complete_tag,
  dispatch_if.buffer            disp,
  retire_if.buffer              ret
);

  localparam int idx_w = $clog2(rob_depth);
  localparam int cnt_w = $clog2(rob_depth + 1);

  rename_pkg::rob_entry_t entries [rob_depth];

  logic [idx_w-1:0] head;
  logic [idx_w-1:0] tail;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             push;
  logic             pop;
  // slot holds a live instruction
  logic [rob_depth-1:0] occupied;
  // completion tag hits this slot
  logic [rob_depth-1:0] match;

  assign full      = (count == cnt_w'(rob_depth));
  assign disp.ready = !full;
  assign push      = disp.valid && disp.ready;

  //////////////////////////////////////////////////////////////////////
  // completion match
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < rob_depth; i++) begin : g_slot
    logic [idx_w-1:0] offset;

    // distance from head, live when inside the count
    assign offset      = idx_w'(i) - head;
    assign occupied[i] = cnt_w'(offset) < count;
    assign match[i]    = complete_valid && occupied[i] &&
                         (entries[i].new_tag == complete_tag);
  end

  //////////////////////////////////////////////////////////////////////
  // head presented to retire
  //////////////////////////////////////////////////////////////////////

  // done bit set at an earlier edge, so retire trails completion
  // nothing pops on a flush edge
  assign ret.valid     = (count != '0) && entries[head].done && !flush;
  assign ret.arch_dest = entries[head].arch_dest;
  assign ret.new_tag   = entries[head].new_tag;
  assign ret.old_tag   = entries[head].old_tag;

  assign pop = ret.valid;

  always_ff @(posedge clock) begin
    for (int i = 0; i < rob_depth; i++) begin
      if (match[i]) begin
        entries[i].done <= 1'b1;
      end
    end
    // new slot starts not done
    if (push) begin
      entries[tail] <= '{arch_dest: disp.arch_dest, new_tag: disp.new_tag,
                         old_tag: disp.old_tag, done: 1'b0};
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // tags in flight are unique, so a completion hits one slot at most
  a_single_match: assert property (@(posedge clock) disable iff (reset)
    complete_valid |-> $onehot0(match));

endmodule

`default_nettype wire

// File: hw/rename_stage.sv
`default_nettype none

module rename_stage #(
  parameter int num_phys_regs = rename_pkg::NUM_PHYS_REGS
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  dispatch_valid,
  input  rename_pkg::arch_reg_t src_a,
  input  rename_pkg::arch_reg_t src_b,
  input  rename_pkg::arch_reg_t dest,
  output rename_pkg::phys_reg_t src_a_tag,
  output rename_pkg::phys_reg_t src_b_tag,
  output logic                  dispatch_ready,
  input  rename_pkg::arch_map_t arch_map,
  input  logic                  freed_valid,
  input  rename_pkg::phys_reg_t freed_tag,
  dispatch_if.producer          disp
);

  // free list slots for the tags beyond the architectural set
  localparam int fl_depth = num_phys_regs - rename_pkg::NUM_ARCH_REGS;
  // extra msb tells full from empty
  localparam int ptr_w    = $clog2(fl_depth) + 1;

  rename_pkg::arch_map_t map_table;
  rename_pkg::phys_reg_t free_list [fl_depth];

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  // head position just past the last retired allocation
  logic [ptr_w-1:0] retire_ptr;
  logic [ptr_w-1:0] fl_count;
  logic             fl_empty;
  logic             alloc;

  assign fl_count = tail - head;
  assign fl_empty = (fl_count == '0);

  //////////////////////////////////////////////////////////////////////
  // dispatch side
  //////////////////////////////////////////////////////////////////////

  // reads see the map before this instruction's own write
  assign src_a_tag = map_table[src_a];
  assign src_b_tag = map_table[src_b];

  assign dispatch_ready = !fl_empty && disp.ready && !flush;

  assign disp.valid     = dispatch_valid && !fl_empty && !flush;
  assign disp.arch_dest = dest;
  assign disp.new_tag   = free_list[head[ptr_w-2:0]];
  assign disp.old_tag   = map_table[dest];

  assign alloc = disp.valid && disp.ready;

  // speculative map restored from the retired map on flush
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
        map_table[r] <= rename_pkg::phys_reg_t'(r);
      end
    end else if (flush) begin
      map_table <= arch_map;
    end else if (alloc) begin
      map_table[dest] <= disp.new_tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // free list ring
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // ring starts full with the spare tags in order
      for (int i = 0; i < fl_depth; i++) begin
        free_list[i] <= rename_pkg::phys_reg_t'(rename_pkg::NUM_ARCH_REGS + i);
      end
    end else if (freed_valid) begin
      free_list[tail[ptr_w-2:0]] <= freed_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= ptr_w'(fl_depth);
      retire_ptr <= '0;
    end else begin
      // in-flight allocations go back onto the ring
      if (flush) begin
        head <= retire_ptr;
      end else if (alloc) begin
        head <= head + 1'b1;
      end
      // every retire commits the oldest allocation and frees one tag
      if (freed_valid) begin
        tail       <= tail + 1'b1;
        retire_ptr <= retire_ptr + 1'b1;
      end
    end
  end

  // retire never returns more tags than the ring can hold
  a_free_not_full: assert property (@(posedge clock) disable iff (reset)
    freed_valid |-> fl_count != ptr_w'(fl_depth));

endmodule

`default_nettype wire

// File: hw/rename_if.sv
`default_nettype none

// rename stage into reorder buffer
interface dispatch_if;
  logic                  valid;
  // low when the reorder buffer is full
  logic                  ready;
  rename_pkg::arch_reg_t arch_dest;
  rename_pkg::phys_reg_t new_tag;
  rename_pkg::phys_reg_t old_tag;

  modport producer (
    output valid, arch_dest, new_tag, old_tag,
    input  ready
  );

  modport buffer (
    input  valid, arch_dest, new_tag, old_tag,
    output ready
  );
endinterface

// reorder buffer head into retire stage
// no ready, the consumer takes every valid head
interface retire_if;
  logic                  valid;
  rename_pkg::arch_reg_t arch_dest;
  rename_pkg::phys_reg_t new_tag;
  rename_pkg::phys_reg_t old_tag;

  modport buffer   (output valid, arch_dest, new_tag, old_tag);
  modport consumer (input  valid, arch_dest, new_tag, old_tag);
endinterface

`default_nettype wire

// File: hw/rename_pkg.sv
`default_nettype none

package rename_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  // architectural register count
  localparam int NUM_ARCH_REGS = 32;
  // physical tags, the top eight start out free
  localparam int NUM_PHYS_REGS = 40;
  // in-flight instructions
  localparam int ROB_DEPTH     = 8;

  //////////////////////////////////////////////////////////////////////
  // tag and map types
  //////////////////////////////////////////////////////////////////////

  typedef logic [4:0] arch_reg_t;
  typedef logic [5:0] phys_reg_t;

  // one tag per architectural register, index r holds the tag of r
  typedef phys_reg_t [NUM_ARCH_REGS-1:0] arch_map_t;

  // one reorder buffer slot
  typedef struct packed {
    arch_reg_t arch_dest;
    phys_reg_t new_tag;
    // tag to hand back to the free list at retire
    phys_reg_t old_tag;
    logic      done;
  } rob_entry_t;

endpackage

`default_nettype wire
